//--- soc.f
soc_pkg.sv
bus_decoder.sv
bus_arbiter.sv
tim.sv
clint.sv
soc.sv
soc_tb.sv

//--- Makefile
TOP = soc_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module $(TOP) -f soc.f -o soc_sim
	@out="$$(./obj_dir/soc_sim)"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

  import soc_pkg::*;

  localparam int num_rounds = 12;
  localparam int planned_accesses = num_rounds * 6 + 25;

  logic clock;
  logic rst_n;
  mem_req_t imem_req;
  mem_rsp_t imem_rsp;
  mem_req_t dmem_req;
  mem_rsp_t dmem_rsp;
  mem_req_t uart_req;
  mem_rsp_t uart_rsp;
  logic msip;
  logic mtip;
  logic [63:0] mtime;

  int mismatch_count = 0;
  int fail_count = 0;
  mem_req_t uart_expect = '0;   // shape of the next uart request, valid low when none is due
  logic [xlen-1:0] tim0_model [tim_depth];
  logic [xlen-1:0] tim1_model [tim_depth];
  logic [63:0] mtimecmp_model;
  logic msip_model;

  soc i_dut (
    .clock(clock), .rst_n(rst_n),
    .imem_req(imem_req), .imem_rsp(imem_rsp),
    .dmem_req(dmem_req), .dmem_rsp(dmem_rsp),
    .uart_req(uart_req), .uart_rsp(uart_rsp),
    .msip(msip), .mtip(mtip), .mtime(mtime)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [xlen-1:0] merge_bytes(logic [xlen-1:0] old_word,
                                                  logic [xlen-1:0] new_word,
                                                  logic [strb_w-1:0] strb);
    logic [xlen-1:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic logic [xlen-1:0] word_addr(logic [xlen-1:0] base, int off);
    return base + (32'(off) << 2);
  endfunction

  task automatic check_equal(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] expected);
    if (got !== expected) begin
      mismatch_count++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  // one request on the data (1) or instruction (0) port, held until ready
  task automatic bus_access(input logic data_side, input logic [xlen-1:0] addr,
                            input logic [xlen-1:0] wdata, input logic [strb_w-1:0] wstrb,
                            input logic timed, output logic [xlen-1:0] rdata);
    mem_req_t req;
    mem_rsp_t rsp;
    int cycles;
    req = '{1'b1, !data_side, addr, wdata, wstrb};
    @(posedge clock);
    if (data_side) dmem_req <= req;
    else imem_req <= req;
    cycles = 0;
    rsp = '0;
    while (!rsp.ready && cycles < 100) begin
      @(posedge clock);
      cycles++;
      rsp = data_side ? dmem_rsp : imem_rsp;
    end
    if (data_side) dmem_req <= '0;
    else imem_req <= '0;
    if (!rsp.ready) begin
      fail_count++;
      $display("access to %h got no ready at %0t", addr, $time);
    end else if (timed) begin
      check_equal("access latency", 32'(cycles), 32'd2);   // drive edge, accept edge, ready
    end
    rdata = rsp.rdata;
  endtask

  // answers after 1 to 5 cycles with the inverted offset as read data
  initial begin : uart_model
    int delay;
    uart_rsp <= '0;
    forever begin
      @(posedge clock);
      if (rst_n && uart_req.valid) begin
        if (!uart_expect.valid) begin
          fail_count++;
          $display("unexpected uart request for %h at %0t", uart_req.addr, $time);
        end else begin
          check_equal("uart_req.addr", uart_req.addr, uart_expect.addr);
          check_equal("uart_req.instr", 32'(uart_req.instr), 32'(uart_expect.instr));
          check_equal("uart_req.wdata", uart_req.wdata, uart_expect.wdata);
          check_equal("uart_req.wstrb", 32'(uart_req.wstrb), 32'(uart_expect.wstrb));
        end
        delay = $urandom_range(1, 5);
        repeat (delay - 1) @(posedge clock);
        uart_rsp.rdata <= ~uart_req.addr;
        uart_rsp.ready <= 1'b1;
        @(posedge clock);
        uart_rsp <= '0;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clock)
    (!rst_n || $rose(rst_n)) |->
      !(imem_rsp.ready || dmem_rsp.ready || uart_req.valid || msip || mtip))
    else begin
      fail_count++;
      $display("outputs were not quiet around reset at %0t", $time);
    end

  a_iready_pulse: assert property (@(posedge clock) disable iff (!rst_n)
    imem_rsp.ready |=> !imem_rsp.ready)
    else begin
      fail_count++;
      $display("instruction ready lasted more than one cycle at %0t", $time);
    end

  a_dready_pulse: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_rsp.ready |=> !dmem_rsp.ready)
    else begin
      fail_count++;
      $display("data ready lasted more than one cycle at %0t", $time);
    end

  a_iready_owned: assert property (@(posedge clock) disable iff (!rst_n)
    imem_rsp.ready |-> imem_req.valid)
    else begin
      fail_count++;
      $display("instruction ready without a pending request at %0t", $time);
    end

  a_dready_owned: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_rsp.ready |-> dmem_req.valid)
    else begin
      fail_count++;
      $display("data ready without a pending request at %0t", $time);
    end

  a_mtime_up: assert property (@(posedge clock) disable iff (!rst_n)
    mtime >= $past(mtime))
    else begin
      fail_count++;
      $display("mtime went backwards at %0t", $time);
    end

  // mtimecmp is written once and mtime only grows, so mtip cannot fall
  a_mtip_holds: assert property (@(posedge clock) disable iff (!rst_n)
    mtip |=> mtip)
    else begin
      fail_count++;
      $display("mtip dropped after it was raised at %0t", $time);
    end

  initial begin : stimulus
    int off;
    int offs [num_rounds];
    int waited;
    logic side;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wd;
    logic [xlen-1:0] rd;
    logic [xlen-1:0] rd_i;
    logic [xlen-1:0] lo1;
    logic [xlen-1:0] lo2;
    logic [xlen-1:0] hi;
    logic [strb_w-1:0] strb;
    logic [63:0] target;
    void'($urandom(98));
    imem_req <= '0;
    dmem_req <= '0;
    rst_n <= 1'b1;
    #1 rst_n <= 1'b0;
    repeat (8) @(posedge clock);
    rst_n <= 1'b1;
    repeat (2) @(posedge clock);

    for (int i = 0; i < num_rounds; i++) begin
      off = $urandom_range(0, tim_depth - 1);
      offs[i] = off;
      wd = $urandom;   // whole words first so no model byte stays unknown
      bus_access(1'b1, word_addr(tim0_base_addr, off), wd, 4'hf, 1'b1, rd);
      tim0_model[off] = wd;
      wd = $urandom;
      bus_access(1'b1, word_addr(tim1_base_addr, off), wd, 4'hf, 1'b1, rd);
      tim1_model[off] = wd;
      wd = $urandom;
      strb = 4'($urandom_range(1, 15));
      bus_access(1'b1, word_addr(tim0_base_addr, off), wd, strb, 1'b1, rd);
      tim0_model[off] = merge_bytes(tim0_model[off], wd, strb);
      wd = $urandom;
      strb = 4'($urandom_range(1, 15));
      bus_access(1'b1, word_addr(tim1_base_addr, off), wd, strb, 1'b1, rd);
      tim1_model[off] = merge_bytes(tim1_model[off], wd, strb);
    end
    for (int i = 0; i < num_rounds; i++) begin
      side = 1'(i % 2);
      bus_access(side, word_addr(tim0_base_addr, offs[i]), '0, '0, 1'b1, rd);
      check_equal("tim0 read", rd, tim0_model[offs[i]]);
      bus_access(!side, word_addr(tim1_base_addr, offs[i]), '0, '0, 1'b1, rd);
      check_equal("tim1 read", rd, tim1_model[offs[i]]);
    end

    // the idle arbiter serves the data side first
    for (int i = 0; i < 4; i++) begin
      off = offs[i];
      wd = $urandom;
      strb = 4'($urandom_range(1, 15));
      if (i % 2 == 0) begin
        fork
          bus_access(1'b1, word_addr(tim0_base_addr, off), wd, strb, 1'b0, rd);
          bus_access(1'b0, word_addr(tim0_base_addr, off), '0, '0, 1'b0, rd_i);
        join
        tim0_model[off] = merge_bytes(tim0_model[off], wd, strb);
        check_equal("tim0 read after contended write", rd_i, tim0_model[off]);
      end else begin
        fork
          bus_access(1'b1, word_addr(tim1_base_addr, off), '0, '0, 1'b0, rd);
          bus_access(1'b0, word_addr(tim1_base_addr, offs[i + 1]), '0, '0, 1'b0, rd_i);
        join
        check_equal("tim1 contended data read", rd, tim1_model[off]);
        check_equal("tim1 contended instruction read", rd_i, tim1_model[offs[i + 1]]);
      end
    end

    for (int i = 0; i < 6; i++) begin
      side = 1'(i % 2);
      addr = 32'($urandom_range(0, 1023)) << 2;
      wd = side ? $urandom : 32'd0;
      strb = side ? 4'($urandom_range(0, 15)) : 4'h0;
      uart_expect = '{1'b1, !side, addr, wd, strb};
      bus_access(side, uart_base_addr + addr, wd, strb, 1'b0, rd);
      check_equal("uart rdata", rd, ~addr);
    end
    uart_expect = '0;

    bus_access(1'b1, clint_base_addr + clint_mtime, '0, '0, 1'b1, lo1);
    bus_access(1'b1, clint_base_addr + clint_mtime + 32'd4, '0, '0, 1'b1, hi);
    bus_access(1'b1, clint_base_addr + clint_mtime, '0, '0, 1'b1, lo2);
    if (lo2 <= lo1) begin
      fail_count++;
      $display("mtime did not advance between reads (%h then %h) at %0t", lo1, lo2, $time);
    end
    target = {hi, lo2} + 64'd50;
    mtimecmp_model = target;
    // high word first, the all ones low half keeps mtip quiet in between
    bus_access(1'b1, clint_base_addr + clint_mtimecmp + 32'd4, target[63:32], 4'hf, 1'b1, rd);
    bus_access(1'b1, clint_base_addr + clint_mtimecmp, target[31:0], 4'hf, 1'b1, rd);
    check_equal("mtip after mtimecmp write", 32'(mtip), 32'd0);
    waited = 0;
    while (!mtip && waited < 60) begin
      @(posedge clock);
      waited++;
    end
    if (!mtip) begin
      fail_count++;
      $display("mtip did not rise within 60 cycles at %0t", $time);
    end
    bus_access(1'b1, clint_base_addr + clint_mtimecmp, '0, '0, 1'b1, rd);
    check_equal("mtimecmp low word", rd, mtimecmp_model[31:0]);
    bus_access(1'b1, clint_base_addr + clint_mtimecmp + 32'd4, '0, '0, 1'b1, rd);
    check_equal("mtimecmp high word", rd, mtimecmp_model[63:32]);
    repeat (10) @(posedge clock);
    check_equal("mtip", 32'(mtip), 32'd1);

    for (int i = 0; i < 2; i++) begin
      msip_model = (i == 0);
      bus_access(1'b1, clint_base_addr + clint_msip, 32'(msip_model), 4'h1, 1'b1, rd);
      check_equal("msip", 32'(msip), 32'(msip_model));
      bus_access(1'b1, clint_base_addr + clint_msip, '0, '0, 1'b1, rd);
      check_equal("msip register", rd, 32'(msip_model));
    end

    repeat (5) @(posedge clock);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (planned_accesses * 20 + 2000) @(posedge clock);
    fail_count++;
    $display("watchdog expired before the tests finished at %0t", $time);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- soc.sv
`timescale 1ns/1ps

module soc (
  input  logic clock,
  input  logic rst_n,
  input  soc_pkg::mem_req_t imem_req,
  output soc_pkg::mem_rsp_t imem_rsp,
  input  soc_pkg::mem_req_t dmem_req,
  output soc_pkg::mem_rsp_t dmem_rsp,
  output soc_pkg::mem_req_t uart_req,
  input  soc_pkg::mem_rsp_t uart_rsp,
  output logic msip,
  output logic mtip,
  output logic [63:0] mtime
);

  import soc_pkg::*;

  // per target links on the decoder side, indexed by target_e
  mem_req_t ireq_tgt [num_targets];
  mem_rsp_t irsp_tgt [num_targets];
  mem_req_t dreq_tgt [num_targets];
  mem_rsp_t drsp_tgt [num_targets];

  mem_req_t tim0_req;
  mem_rsp_t tim0_rsp;
  mem_req_t tim1_req;
  mem_rsp_t tim1_rsp;
  mem_req_t clint_req;
  mem_rsp_t clint_rsp;

  bus_decoder i_idec (
    .clock(clock), .rst_n(rst_n),
    .req(imem_req), .rsp(imem_rsp),
    .tgt_req(ireq_tgt), .tgt_rsp(irsp_tgt)
  );

  bus_decoder i_ddec (
    .clock(clock), .rst_n(rst_n),
    .req(dmem_req), .rsp(dmem_rsp),
    .tgt_req(dreq_tgt), .tgt_rsp(drsp_tgt)
  );

  bus_arbiter i_arb_tim0 (
    .clock(clock), .rst_n(rst_n),
    .ireq(ireq_tgt[tgt_tim0]), .irsp(irsp_tgt[tgt_tim0]),
    .dreq(dreq_tgt[tgt_tim0]), .drsp(drsp_tgt[tgt_tim0]),
    .treq(tim0_req), .trsp(tim0_rsp)
  );

  bus_arbiter i_arb_tim1 (
    .clock(clock), .rst_n(rst_n),
    .ireq(ireq_tgt[tgt_tim1]), .irsp(irsp_tgt[tgt_tim1]),
    .dreq(dreq_tgt[tgt_tim1]), .drsp(drsp_tgt[tgt_tim1]),
    .treq(tim1_req), .trsp(tim1_rsp)
  );

  bus_arbiter i_arb_clint (
    .clock(clock), .rst_n(rst_n),
    .ireq(ireq_tgt[tgt_clint]), .irsp(irsp_tgt[tgt_clint]),
    .dreq(dreq_tgt[tgt_clint]), .drsp(drsp_tgt[tgt_clint]),
    .treq(clint_req), .trsp(clint_rsp)
  );

  // the uart sits outside, its arbiter drives the top level port
  bus_arbiter i_arb_uart (
    .clock(clock), .rst_n(rst_n),
    .ireq(ireq_tgt[tgt_uart]), .irsp(irsp_tgt[tgt_uart]),
    .dreq(dreq_tgt[tgt_uart]), .drsp(drsp_tgt[tgt_uart]),
    .treq(uart_req), .trsp(uart_rsp)
  );

  tim i_tim0 (.clock(clock), .rst_n(rst_n), .req(tim0_req), .rsp(tim0_rsp));

  tim i_tim1 (.clock(clock), .rst_n(rst_n), .req(tim1_req), .rsp(tim1_rsp));

  clint i_clint (
    .clock(clock), .rst_n(rst_n),
    .req(clint_req), .rsp(clint_rsp),
    .msip(msip), .mtip(mtip), .mtime(mtime)
  );

endmodule

//--- clint.sv
`timescale 1ns/1ps

module clint (
  input  logic clock,
  input  logic rst_n,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic msip,
  output logic mtip,
  output logic [63:0] mtime
);

  import soc_pkg::*;

  logic msip_q;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtime_q;
  logic [xlen-1:0] rd_word;
  logic [xlen-1:0] rdata_q;
  logic ready_q;
  logic accept;
  logic wr;

  assign accept = req.valid && !ready_q;
  assign wr = accept && (|req.wstrb);

  always_comb begin
    case (req.addr)
      clint_msip: rd_word = {{(xlen-1){1'b0}}, msip_q};
      clint_mtimecmp: rd_word = mtimecmp_q[31:0];
      clint_mtimecmp + 32'd4: rd_word = mtimecmp_q[63:32];
      clint_mtime: rd_word = mtime_q[31:0];
      clint_mtime + 32'd4: rd_word = mtime_q[63:32];
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (accept) rdata_q <= rd_word;
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      msip_q <= 1'b0;
      mtimecmp_q <= '1;   // far future, so no timer interrupt out of reset
      mtime_q <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
      mtime_q <= mtime_q + 64'd1;
      // a write to an mtime word replaces the count for that word
      if (wr) begin
        case (req.addr)
          clint_msip: begin
            if (req.wstrb[0]) msip_q <= req.wdata[0];
          end
          clint_mtimecmp: begin
            mtimecmp_q[31:0] <= apply_strb(mtimecmp_q[31:0], req.wdata, req.wstrb);
          end
          clint_mtimecmp + 32'd4: begin
            mtimecmp_q[63:32] <= apply_strb(mtimecmp_q[63:32], req.wdata, req.wstrb);
          end
          clint_mtime: begin
            mtime_q[31:0] <= apply_strb(mtime_q[31:0], req.wdata, req.wstrb);
          end
          clint_mtime + 32'd4: begin
            mtime_q[63:32] <= apply_strb(mtime_q[63:32], req.wdata, req.wstrb);
          end
          default: ;
        endcase
      end
    end
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ready = ready_q;

  assign msip = msip_q;
  assign mtip = (mtime_q >= mtimecmp_q);
  assign mtime = mtime_q;

endmodule

//--- tim.sv
`timescale 1ns/1ps

module tim (
  input  logic clock,
  input  logic rst_n,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp
);

  import soc_pkg::*;

  logic [xlen-1:0] mem [tim_depth];
  logic [tim_idx_w-1:0] idx;
  logic [xlen-1:0] rdata_q;
  logic ready_q;
  logic accept;

  assign idx = req.addr[tim_idx_w+1:2];   // byte offset to word index
  assign accept = req.valid && !ready_q;

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata_q <= mem[idx];
      if (|req.wstrb) begin
        mem[idx] <= apply_strb(mem[idx], req.wdata, req.wstrb);
      end
    end
  end

  // ready is high for the single cycle after the request was taken
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ready = ready_q;

  // the decoder window must match the memory size
  a_in_range: assert property (@(posedge clock) disable iff (!rst_n)
    req.valid |-> (req.addr >> 2) < tim_depth)
    else $error("tim: word offset outside the memory");

endmodule

//--- bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic clock,
  input  logic rst_n,
  input  soc_pkg::mem_req_t ireq,
  output soc_pkg::mem_rsp_t irsp,
  input  soc_pkg::mem_req_t dreq,
  output soc_pkg::mem_rsp_t drsp,
  output soc_pkg::mem_req_t treq,
  input  soc_pkg::mem_rsp_t trsp
);

  import soc_pkg::*;

  logic busy_q;       // an access is open on the target
  logic gnt_data_q;   // set when the data side owns the open access
  logic sel_data;

  // while idle the choice follows dreq directly so the request
  // reaches the target in the same cycle
  assign sel_data = busy_q ? gnt_data_q : dreq.valid;

  always_comb begin
    if (sel_data) begin
      treq = dreq;
    end else begin
      treq = ireq;
    end
  end

  always_comb begin
    irsp.rdata = trsp.rdata;
    irsp.ready = trsp.ready && busy_q && !gnt_data_q;
    drsp.rdata = trsp.rdata;
    drsp.ready = trsp.ready && busy_q && gnt_data_q;
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      gnt_data_q <= 1'b0;
    end else if (!busy_q) begin
      busy_q <= treq.valid;
      gnt_data_q <= sel_data;
    end else if (trsp.ready) begin
      busy_q <= 1'b0;   // back to idle so a waiting side can be granted next
    end
  end

  // the target keeps seeing the same request until it answers
  a_grant_stable: assert property (@(posedge clock) disable iff (!rst_n)
    busy_q && !trsp.ready |=> $stable(treq))
    else $error("bus_arbiter: granted request moved in the middle of an access");

  // initiators keep valid up to the edge where they see ready
  a_irsp_owner: assert property (@(posedge clock) disable iff (!rst_n)
    irsp.ready |-> ireq.valid)
    else $error("bus_arbiter: instruction side got ready without a request");

  a_drsp_owner: assert property (@(posedge clock) disable iff (!rst_n)
    drsp.ready |-> dreq.valid)
    else $error("bus_arbiter: data side got ready without a request");

endmodule

//--- bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic clock,
  input  logic rst_n,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output soc_pkg::mem_req_t tgt_req [soc_pkg::num_targets],
  input  soc_pkg::mem_rsp_t tgt_rsp [soc_pkg::num_targets]
);

  import soc_pkg::*;

  logic [num_targets-1:0] hit;
  logic [num_targets-1:0] rdy;
  logic [xlen-1:0] base;
  logic [xlen-1:0] offset;

  // regions do not overlap, so at most one hit bit is set
  always_comb begin
    hit = '0;
    base = '0;
    for (int t = 0; t < num_targets; t++) begin
      if (req.addr >= region_base[t] && req.addr < region_top[t]) begin
        hit[t] = 1'b1;
        base = region_base[t];
      end
    end
  end

  assign offset = req.addr - base;

  always_comb begin
    for (int t = 0; t < num_targets; t++) begin
      tgt_req[t].valid = req.valid && hit[t];   // unmapped addresses go nowhere
      tgt_req[t].instr = req.instr;
      tgt_req[t].addr = offset;
      tgt_req[t].wdata = req.wdata;
      tgt_req[t].wstrb = req.wstrb;
    end
  end

  always_comb begin
    for (int t = 0; t < num_targets; t++) begin
      rdy[t] = tgt_rsp[t].ready;
    end
  end

  // hand back whichever target answered this cycle
  always_comb begin
    rsp = '0;
    for (int t = 0; t < num_targets; t++) begin
      if (rdy[t]) rsp = tgt_rsp[t];
    end
  end

  // arbiters give this side one target at a time, so two answers
  // at once mean a grant leaked to the wrong initiator
  a_one_ready: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0(rdy))
    else $error("bus_decoder: more than one target answered in one cycle");

endmodule

//--- soc_pkg.sv
package soc_pkg;

  localparam int xlen = 32;
  localparam int strb_w = 4;

  localparam int tim_depth = 256;
  localparam int tim_idx_w = $clog2(tim_depth);

  localparam logic [xlen-1:0] tim0_base_addr = 32'h0001_0000;
  localparam logic [xlen-1:0] tim0_top_addr = 32'h0001_0400;
  localparam logic [xlen-1:0] tim1_base_addr = 32'h0002_0000;
  localparam logic [xlen-1:0] tim1_top_addr = 32'h0002_0400;
  localparam logic [xlen-1:0] clint_base_addr = 32'h0200_0000;
  localparam logic [xlen-1:0] clint_top_addr = 32'h0201_0000;
  localparam logic [xlen-1:0] uart_base_addr = 32'h1000_0000;
  localparam logic [xlen-1:0] uart_top_addr = 32'h1000_1000;

  // offsets inside the clint window, high words sit 4 bytes above
  localparam logic [xlen-1:0] clint_msip = 32'h0000_0000;
  localparam logic [xlen-1:0] clint_mtimecmp = 32'h0000_4000;
  localparam logic [xlen-1:0] clint_mtime = 32'h0000_bff8;

  typedef enum logic [1:0] {
    tgt_tim0,
    tgt_tim1,
    tgt_clint,
    tgt_uart
  } target_e;

  localparam int num_targets = 4;

  // region tables follow the order of target_e
  localparam logic [xlen-1:0] region_base [num_targets] =
    '{tim0_base_addr, tim1_base_addr, clint_base_addr, uart_base_addr};
  localparam logic [xlen-1:0] region_top [num_targets] =
    '{tim0_top_addr, tim1_top_addr, clint_top_addr, uart_top_addr};

  typedef struct packed {
    logic valid;
    logic instr;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [strb_w-1:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic ready;
  } mem_rsp_t;

  // merges the strobed bytes of wdata into an existing word
  function automatic logic [xlen-1:0] apply_strb(logic [xlen-1:0] old_word,
                                                 logic [xlen-1:0] wdata,
                                                 logic [strb_w-1:0] wstrb);
    logic [xlen-1:0] merged;
    merged = old_word;
    for (int b = 0; b < strb_w; b++) begin
      if (wstrb[b]) merged[8*b +: 8] = wdata[8*b +: 8];
    end
    return merged;
  endfunction

endpackage
